/* bp_frontend.f */
+incdir+.
bp_types_pkg.sv
bp_predecode.sv
bp_resolve_merge.sv
branch_predictor.sv
bp_frontend.sv
tb_bp_frontend.sv

/* Makefile */
# verilator build and run of the branch prediction front end testbench

BIN  := obj_dir/Vtb_bp_frontend
SRCS := $(wildcard *.sv *.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) bp_frontend.f
	verilator --binary --timing --timescale 1ns/1ns -f bp_frontend.f \
		--top-module tb_bp_frontend -Mdir obj_dir

run: $(BIN)
	./$(BIN) > sim.log 2>&1
	cat sim.log
	! grep -q "Simulation failed" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb_bp_frontend.sv */
`timescale 1ns/1ns

`include "bp_config.svh"

module tb_bp_frontend
	import bp_types_pkg::*;
();

	typedef resolve_t [`BP_LANES-1:0] lanes_t;

	// opcode classes for stimulus
	localparam logic [1:0] cls_br    = 2'd0;
	localparam logic [1:0] cls_jal   = 2'd1;
	localparam logic [1:0] cls_jalr  = 2'd2;
	localparam logic [1:0] cls_other = 2'd3;

	logic   clk;
	logic   rst;
	fetch_t fetch;
	lanes_t resolve;
	pred_t  pred;

	// reference model state
	ctr_t   model_ctr [`BP_ENTRIES];
	// lanes driven last cycle, counters move one edge after sampling
	lanes_t res_pend;
	pred_t  exp_q [$];
	int     due_q [$];

	logic [15:0] lfsr;
	int          cycle = 0;
	int          err_cnt;
	int          chk_cnt;
	int          pred_cnt;

	bp_frontend dut0 (
		.clk     (clk),
		.rst     (rst),
		.fetch   (fetch),
		.resolve (resolve),
		.pred    (pred)
	);

	// 20 ns clock
	initial begin
		clk = 1'b0;
		forever begin
			#10;
			clk = ~clk;
		end
	end

	// galois lfsr, one step per bit
	function automatic logic rand_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b) begin
			lfsr = lfsr ^ 16'hB400;
		end
		return b;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], rand_bit()};
		end
		return v;
	endfunction

	// small index set so entries collide often
	function automatic bp_idx_t pick_idx();
		logic [31:0] t;
		bp_idx_t     idx;
		t = rand_bits(2);
		case (t[1:0])
			2'd0: idx = 6'h05;
			2'd1: idx = 6'h12;
			2'd2: idx = 6'h2a;
			default: idx = 6'h3f;
		endcase
		return idx;
	endfunction

	// random upper bits, chosen index in [7:2], word aligned
	function automatic logic [31:0] make_pc(input bp_idx_t idx);
		logic [31:0] t;
		t = rand_bits(24);
		return {t[23:0], idx, 2'b00};
	endfunction

	// sign extended immediate for the class
	function automatic logic [31:0] rand_imm(input logic [1:0] cls);
		logic [31:0] t;
		logic [31:0] imm;
		if (cls == cls_jal) begin
			t = rand_bits(20);
			imm = {{11{t[19]}}, t[19:0], 1'b0};
		end else if (cls == cls_br) begin
			t = rand_bits(12);
			imm = {{19{t[11]}}, t[11:0], 1'b0};
		end else begin
			t = rand_bits(12);
			imm = {{20{t[11]}}, t[11:0]};
		end
		return imm;
	endfunction

	// encode the immediate into an rv32i word
	// register and funct fields are random filler
	function automatic fetch_t make_fetch(input logic [31:0] pc, input logic [1:0] cls,
		input logic [31:0] imm);
		logic [31:0] fill;
		fetch_t      f;
		fill = rand_bits(25);
		f.valid = 1'b1;
		f.pc    = pc;
		case (cls)
			cls_br:   f.instr = {imm[12], imm[10:5], fill[12:0], imm[4:1], imm[11], 7'b1100011};
			cls_jal:  f.instr = {imm[20], imm[10:1], imm[11], imm[19:12], fill[4:0], 7'b1101111};
			cls_jalr: f.instr = {imm[11:0], fill[4:0], 3'b000, fill[9:5], 7'b1100111};
			default:  f.instr = {fill[24:0], 7'b0010011};
		endcase
		return f;
	endfunction

	// saturating step, clamped to 0..3
	function automatic ctr_t ctr_next(input ctr_t c, input logic taken);
		int v;
		v = {30'd0, c};
		if (taken) begin
			v = v + 1;
		end else begin
			v = v - 1;
		end
		if (v > 3) begin
			v = 3;
		end
		if (v < 0) begin
			v = 0;
		end
		return v[1:0];
	endfunction

	// expected prediction from the model counters
	function automatic pred_t expect_pred(input logic [31:0] pc, input logic [1:0] cls,
		input logic [31:0] imm);
		bp_idx_t idx;
		pred_t   e;
		idx = pc[`BP_IDX_LSB +: `BP_IDX_W];
		e.valid = 1'b1;
		e.pc    = pc;
		case (cls)
			cls_br:  e.br_taken = model_ctr[idx][1];
			cls_jal: e.br_taken = 1'b1;
			default: e.br_taken = 1'b0;
		endcase
		e.br_addr = e.br_taken ? pc + imm : pc + 32'd4;
		return e;
	endfunction

	// lane 0 then lane 1, commit order
	task automatic apply_resolves(input lanes_t r);
		bp_idx_t idx;
		for (int i = 0; i < `BP_LANES; i++) begin
			if (r[i].valid) begin
				idx = r[i].pc[`BP_IDX_LSB +: `BP_IDX_W];
				model_ctr[idx] = ctr_next(model_ctr[idx], r[i].taken);
			end
		end
	endtask

	// one or two lanes on the same index
	function automatic lanes_t lanes_at(input bp_idx_t idx, input int n, input logic t0,
		input logic t1);
		lanes_t r;
		r = '0;
		r[0].valid = 1'b1;
		r[0].pc    = make_pc(idx);
		r[0].taken = t0;
		if (n == 2) begin
			r[1].valid = 1'b1;
			r[1].pc    = make_pc(idx);
			r[1].taken = t1;
		end
		return r;
	endfunction

	task automatic compare_flag(input string name, input logic got, input logic want);
		chk_cnt++;
		if (got !== want) begin
			err_cnt++;
			$display("error at %0t ns: %s got %b expected %b", $time, name, got, want);
		end
	endtask

	task automatic compare_ctr(input string name, input ctr_t got, input ctr_t want);
		chk_cnt++;
		if (got !== want) begin
			err_cnt++;
			$display("error at %0t ns: %s got %b expected %b", $time, name, got, want);
		end
	endtask

	task automatic compare_pred(input pred_t got, input pred_t want);
		chk_cnt++;
		if (got.valid !== want.valid) begin
			err_cnt++;
			$display("error at %0t ns: pred.valid got %b expected %b", $time, got.valid,
				want.valid);
		end
		if (got.pc !== want.pc) begin
			err_cnt++;
			$display("error at %0t ns: pred.pc got %h expected %h", $time, got.pc, want.pc);
		end
		if (got.br_taken !== want.br_taken) begin
			err_cnt++;
			$display("error at %0t ns: pred.br_taken got %b expected %b", $time,
				got.br_taken, want.br_taken);
		end
		if (got.br_addr !== want.br_addr) begin
			err_cnt++;
			$display("error at %0t ns: pred.br_addr got %h expected %h", $time,
				got.br_addr, want.br_addr);
		end
	endtask

	// drive 2 ns after the edge, model updates in the same step
	task automatic drive_cycle(input fetch_t f, input logic [1:0] cls, input logic [31:0] imm,
		input lanes_t r, output pred_t e);
		@(posedge clk);
		#2;
		// lanes sampled at the edge just passed land before this fetch's lookup
		apply_resolves(res_pend);
		res_pend = r;
		fetch    = f;
		resolve  = r;
		e        = '0;
		if (f.valid) begin
			e = expect_pred(f.pc, cls, imm);
			exp_q.push_back(e);
			due_q.push_back(cycle + 2);
		end
	endtask

	task automatic idle();
		pred_t e;
		drive_cycle('0, cls_other, 32'd0, '0, e);
	endtask

	// directed fetch, plus a check of the expected direction
	task automatic fetch_at(input bp_idx_t idx, input logic [1:0] cls, input logic taken_exp,
		input lanes_t r);
		logic [31:0] pc;
		logic [31:0] imm;
		fetch_t      f;
		pred_t       e;
		pc  = make_pc(idx);
		imm = rand_imm(cls);
		f   = make_fetch(pc, cls, imm);
		drive_cycle(f, cls, imm, r, e);
		compare_flag("expected br_taken", e.br_taken, taken_exp);
	endtask

	task automatic resolve_at(input lanes_t r);
		pred_t e;
		drive_cycle('0, cls_other, 32'd0, r, e);
	endtask

	task automatic random_cycle(input logic force_fetch);
		logic [31:0] t;
		logic [1:0]  cls;
		logic [31:0] imm;
		fetch_t      f;
		lanes_t      r;
		pred_t       e;
		t   = rand_bits(2);
		cls = t[1:0];
		imm = rand_imm(cls);
		f   = make_fetch(make_pc(pick_idx()), cls, imm);
		// about three fetches in four
		t = rand_bits(2);
		f.valid = force_fetch || (t[1:0] != 2'b00);
		for (int i = 0; i < `BP_LANES; i++) begin
			t = rand_bits(2);
			r[i].valid = t[0];
			r[i].taken = t[1];
			r[i].pc    = make_pc(pick_idx());
		end
		// extra same-index pairs
		t = rand_bits(1);
		if (t[0]) begin
			r[1].pc[`BP_IDX_LSB +: `BP_IDX_W] = r[0].pc[`BP_IDX_LSB +: `BP_IDX_W];
		end
		drive_cycle(f, cls, imm, r, e);
	endtask

	// wait for the queue to empty, bounded
	task automatic drain();
		int n;
		n = 0;
		while (exp_q.size() > 0 && n < 10) begin
			idle();
			n++;
		end
		if (exp_q.size() > 0) begin
			err_cnt++;
			$display("timeout: %0d predictions still missing after %0d cycles",
				exp_q.size(), n);
			exp_q.delete();
			due_q.delete();
		end
	endtask

	task automatic check_output();
		pred_t e;
		int    due;
		if (pred.valid) begin
			if (exp_q.size() == 0) begin
				err_cnt++;
				$display("at %0t ns a prediction for pc %h came out with no fetch in flight",
					$time, pred.pc);
			end else begin
				e   = exp_q.pop_front();
				due = due_q.pop_front();
				pred_cnt++;
				if (due != cycle) begin
					err_cnt++;
					$display("error at %0t ns: pred cycle got %0d expected %0d", $time,
						cycle, due);
				end
				compare_pred(pred, e);
			end
		end else if (due_q.size() > 0 && due_q[0] <= cycle) begin
			e   = exp_q.pop_front();
			due = due_q.pop_front();
			err_cnt++;
			$display("at %0t ns the prediction for pc %h never came out", $time, e.pc);
		end
	endtask

	// output monitor, 1 ns after each edge
	initial begin
		forever begin
			@(posedge clk);
			cycle++;
			#1;
			if (!rst) begin
				check_output();
			end
		end
	end

	initial begin
		lfsr     = 16'd62678;
		err_cnt  = 0;
		chk_cnt  = 0;
		pred_cnt = 0;
		rst      = 1'b1;
		fetch    = '0;
		resolve  = '0;
		res_pend = '0;
		for (int e = 0; e < `BP_ENTRIES; e++) begin
			model_ctr[e] = `BP_CTR_RESET;
		end
		repeat (10) @(posedge clk);
		#2;
		rst = 1'b0;
		compare_flag("pred.valid", pred.valid, 1'b0);

		// first lookups, all weakly taken
		fetch_at(6'h05, cls_br, 1'b1, '0);
		fetch_at(6'h12, cls_br, 1'b1, '0);
		fetch_at(6'h2a, cls_br, 1'b1, '0);
		fetch_at(6'h3f, cls_br, 1'b1, '0);
		fetch_at(6'h05, cls_jal, 1'b1, '0);
		fetch_at(6'h05, cls_jalr, 1'b0, '0);
		fetch_at(6'h05, cls_other, 1'b0, '0);
		drain();

		// saturate low, then climb back
		repeat (5) resolve_at(lanes_at(6'h12, 1, 1'b0, 1'b0));
		fetch_at(6'h12, cls_br, 1'b0, '0);
		compare_ctr("model counter 0x12", model_ctr[6'h12], 2'b00);
		resolve_at(lanes_at(6'h12, 1, 1'b1, 1'b0));
		fetch_at(6'h12, cls_br, 1'b0, '0);
		resolve_at(lanes_at(6'h12, 1, 1'b1, 1'b0));
		fetch_at(6'h12, cls_br, 1'b1, '0);
		drain();

		// same index on both lanes
		// 2 -> 3, then T,N gives 2, then N gives 1
		resolve_at(lanes_at(6'h2a, 1, 1'b1, 1'b0));
		resolve_at(lanes_at(6'h2a, 2, 1'b1, 1'b0));
		resolve_at(lanes_at(6'h2a, 1, 1'b0, 1'b0));
		fetch_at(6'h2a, cls_br, 1'b0, '0);
		compare_ctr("model counter 0x2a", model_ctr[6'h2a], 2'b01);
		// 1 -> 0, then N,T gives 1, then T gives 2
		resolve_at(lanes_at(6'h2a, 1, 1'b0, 1'b0));
		resolve_at(lanes_at(6'h2a, 2, 1'b0, 1'b1));
		resolve_at(lanes_at(6'h2a, 1, 1'b1, 1'b0));
		fetch_at(6'h2a, cls_br, 1'b1, '0);
		compare_ctr("model counter 0x2a", model_ctr[6'h2a], 2'b10);
		drain();

		// lookup at the update edge sees old value, next one the new
		fetch_at(6'h3f, cls_br, 1'b1, lanes_at(6'h3f, 1, 1'b0, 1'b0));
		fetch_at(6'h3f, cls_br, 1'b0, '0);
		drain();

		// back-to-back burst
		repeat (16) random_cycle(1'b1);
		drain();

		// random mix of fetches and resolves
		repeat (400) random_cycle(1'b0);
		drain();

		$display("checks %0d, predictions %0d, errors %0d", chk_cnt, pred_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule : tb_bp_frontend

/* bp_frontend.sv */
`timescale 1ns/1ns

`include "bp_config.svh"

module bp_frontend
	import bp_types_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst,
	// fetched word and its pc
	input  fetch_t                   fetch,
	// committed branches, lane 0 older
	input  resolve_t [`BP_LANES-1:0] resolve,
	// prediction, two cycles after fetch
	output pred_t                    pred
);

	// predecode to predictor
	pci_t                     pc_info;
	// merged counter updates
	ctr_upd_t [`BP_LANES-1:0] upd;

	// stage 1, opcode class and target
	bp_predecode u_predecode (
		.clk     (clk),
		.rst     (rst),
		.fetch   (fetch),
		.pc_info (pc_info)
	);

	// resolve path
	// lanes registered here, counters move one edge later
	bp_resolve_merge u_merge (
		.clk     (clk),
		.rst     (rst),
		.resolve (resolve),
		.upd     (upd)
	);

	// stage 2, table lookup and counter update
	branch_predictor u_predictor (
		.clk     (clk),
		.rst     (rst),
		.pc_info (pc_info),
		.upd     (upd),
		.pred    (pred)
	);

endmodule : bp_frontend

/* branch_predictor.sv */
`timescale 1ns/1ns

`include "bp_config.svh"

module branch_predictor
	import bp_types_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst,
	input  pci_t                     pc_info,
	input  ctr_upd_t [`BP_LANES-1:0] upd,
	output pred_t                    pred
);

	// counter table
	ctr_t    ctrs [`BP_ENTRIES];

	// lookup side
	bp_idx_t lk_idx;
	ctr_t    lk_ctr;
	pred_t   pred_nxt;

	// update side, new value per lane
	ctr_t    upd_val [`BP_LANES];

	// one saturating step
	function automatic ctr_t sat_step(input ctr_t c, input logic taken);
		ctr_t r;
		r = c;
		if (taken && (c != 2'b11)) begin
			r = c + 2'b01;
		end else if (!taken && (c != 2'b00)) begin
			r = c - 2'b01;
		end
		return r;
	endfunction

	// lookup reads the table as it stands before this edge's writes
	assign lk_idx = pc_info.pc[`BP_IDX_LSB +: `BP_IDX_W];
	assign lk_ctr = ctrs[lk_idx];

	always_comb begin
		pred_nxt.valid    = pc_info.valid;
		pred_nxt.pc       = pc_info.pc;
		pred_nxt.br_taken = 1'b0;
		// conditional branch follows the counter msb
		if (pc_info.is_br_instr) begin
			pred_nxt.br_taken = lk_ctr[1];
		end
		// jal never consults the table
		if (pc_info.is_jal) begin
			pred_nxt.br_taken = 1'b1;
		end
		// fall through unless predicted taken
		if (pred_nxt.br_taken) begin
			pred_nxt.br_addr = pc_info.branch_pc;
		end else begin
			pred_nxt.br_addr = pc_info.pc + 32'd4;
		end
	end

	// output stage
	always_ff @(posedge clk) begin
		if (rst) begin
			pred.valid <= 1'b0;
		end else begin
			pred <= pred_nxt;
		end
	end

	// next counter value per lane
	// merge guarantees distinct indices across valid lanes
	always_comb begin
		for (int i = 0; i < `BP_LANES; i++) begin
			upd_val[i] = sat_step(ctrs[upd[i].idx], upd[i].first_taken);
			// second outcome goes on top of the first
			if (upd[i].steps == 2'd2) begin
				upd_val[i] = sat_step(upd_val[i], upd[i].second_taken);
			end
		end
	end

	// table write
	// every entry starts weakly taken
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int e = 0; e < `BP_ENTRIES; e++) begin
				ctrs[e] <= `BP_CTR_RESET;
			end
		end else begin
			for (int i = 0; i < `BP_LANES; i++) begin
				if (upd[i].valid) begin
					ctrs[upd[i].idx] <= upd_val[i];
				end
			end
		end
	end

endmodule : branch_predictor

/* bp_resolve_merge.sv */
`timescale 1ns/1ns

`include "bp_config.svh"

module bp_resolve_merge
	import bp_types_pkg::*;
(
	input  logic                            clk,
	input  logic                            rst,
	input  resolve_t [`BP_LANES-1:0]        resolve,
	output ctr_upd_t [`BP_LANES-1:0]        upd
);

	// per lane table index
	bp_idx_t                  lane_idx [`BP_LANES];
	// both lanes land on one counter this cycle
	logic                     same_idx;
	ctr_upd_t [`BP_LANES-1:0] upd_nxt;

	// index taken from the committed pc
	always_comb begin
		for (int i = 0; i < `BP_LANES; i++) begin
			lane_idx[i] = resolve[i].pc[`BP_IDX_LSB +: `BP_IDX_W];
		end
	end

	// collision check between lane 0 and lane 1
	assign same_idx = resolve[0].valid && resolve[1].valid &&
		(lane_idx[0] == lane_idx[1]);

	always_comb begin
		// by default every valid lane is a single step
		for (int i = 0; i < `BP_LANES; i++) begin
			upd_nxt[i].valid        = resolve[i].valid;
			upd_nxt[i].idx          = lane_idx[i];
			upd_nxt[i].steps        = 2'd1;
			upd_nxt[i].first_taken  = resolve[i].taken;
			upd_nxt[i].second_taken = 1'b0;
		end
		// same counter from both lanes
		// fold into lane 0 in commit order since lane 0 is older
		// saturation means up then down is not the same as a zero net step
		if (same_idx) begin
			upd_nxt[0].steps        = 2'd2;
			upd_nxt[0].second_taken = resolve[1].taken;
			// lane 1 already folded into lane 0
			upd_nxt[1].valid        = 1'b0;
		end
	end

	// register the merged updates
	// only the strobes clear on reset
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `BP_LANES; i++) begin
				upd[i].valid <= 1'b0;
			end
		end else begin
			upd <= upd_nxt;
		end
	end

endmodule : bp_resolve_merge

/* bp_predecode.sv */
`timescale 1ns/1ns

`include "bp_config.svh"

module bp_predecode
	import bp_types_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  fetch_t fetch,
	output pci_t   pc_info
);

	// scattered immediates, both already sign extended
	logic [31:0] imm_b;
	logic [31:0] imm_j;
	logic        is_br;
	logic        is_jal;
	logic [31:0] target;
	pci_t        pc_info_nxt;

	// b-type: imm[12|10:5] in [31:25], imm[4:1|11] in [11:7]
	assign imm_b = {{20{fetch.instr[31]}}, fetch.instr[7], fetch.instr[30:25],
		fetch.instr[11:8], 1'b0};

	// j-type: imm[20|10:1|11|19:12] in [31:12]
	assign imm_j = {{12{fetch.instr[31]}}, fetch.instr[19:12], fetch.instr[20],
		fetch.instr[30:21], 1'b0};

	// opcode classification
	always_comb begin
		is_br  = 1'b0;
		is_jal = 1'b0;
		case (fetch.instr[6:0])
			op_br: begin
				is_br = 1'b1;
			end
			op_jal: begin
				is_jal = 1'b1;
			end
			op_jalr: begin
				// target comes from a register, not known at fetch
				// so jalr falls through as a plain instruction
				is_br  = 1'b0;
				is_jal = 1'b0;
			end
			default: begin
				is_br  = 1'b0;
				is_jal = 1'b0;
			end
		endcase
	end

	// pc relative target
	// jal uses the j immediate, everything else the b immediate
	assign target = fetch.pc + (is_jal ? imm_j : imm_b);

	always_comb begin
		pc_info_nxt.valid       = fetch.valid;
		pc_info_nxt.pc          = fetch.pc;
		pc_info_nxt.is_br_instr = is_br;
		pc_info_nxt.is_jal      = is_jal;
		pc_info_nxt.branch_pc   = target;
	end

	// stage register, one cycle
	// only the strobe is cleared on reset
	always_ff @(posedge clk) begin
		if (rst) begin
			pc_info.valid <= 1'b0;
		end else begin
			pc_info <= pc_info_nxt;
		end
	end

endmodule : bp_predecode

/* bp_types_pkg.sv */
`include "bp_config.svh"

package bp_types_pkg;

	// table index into the counter array
	typedef logic [`BP_IDX_W-1:0] bp_idx_t;

	// 2-bit saturating counter
	// 00 strong not taken, 01 weak not taken, 10 weak taken, 11 strong taken
	typedef logic [1:0] ctr_t;

	// rv32i opcodes the predecoder cares about
	typedef enum logic [6:0] {
		op_br   = 7'b1100011,
		op_jal  = 7'b1101111,
		op_jalr = 7'b1100111
	} rv_opcode_t;

	// raw fetch from the icache side
	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic [31:0] instr;
	} fetch_t;

	// predecoded fetch
	// branch_pc is pc plus the sign-extended immediate
	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic        is_br_instr;
		logic        is_jal;
		logic [31:0] branch_pc;
	} pci_t;

	// prediction handed to the pc mux
	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic        br_taken;
		logic [31:0] br_addr;
	} pred_t;

	// one committed branch from the rob
	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic        taken;
	} resolve_t;

	// merged counter update, steps is 1 or 2
	// second_taken only meaningful when steps is 2
	typedef struct packed {
		logic        valid;
		bp_idx_t     idx;
		logic [1:0]  steps;
		logic        first_taken;
		logic        second_taken;
	} ctr_upd_t;

endpackage : bp_types_pkg

/* bp_config.svh */
`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

// counter table depth, one 2-bit counter per entry
`define BP_ENTRIES 64

// lowest pc bit used for the table index
// word aligned fetch, so bits [1:0] carry nothing
`define BP_IDX_LSB 2

// index width follows from the table depth
`define BP_IDX_W $clog2(`BP_ENTRIES)

// commit lanes coming back from the rob each cycle
`define BP_LANES 2

// weakly taken after reset
`define BP_CTR_RESET 2'b10

`endif
